// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mlp_controller
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = *** TEST PASSED ***

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: mlp_controller.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_controller import mlp_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       chipselect,
    input  logic       read,
    input  logic       write,
    input  logic [3:0] address,
    input  word_t      writedata,
    output word_t      readdata,
    output logic [9:0] led_out
);

    word_t        control_reg;
    data_t        input_reg;
    word_t        instr_reg;
    result_t      output_reg;
    logic         result_rdy;

    send_state_e  send_state;
    stream_flit_t flit_q;
    logic         flit_valid;
    logic         flit_ready;

    result_t      result;
    logic         result_valid;
    logic         result_ready;

    logic         host_wr;
    logic         host_rd;
    logic         send_start;
    logic         output_read;
    word_t        read_word;

    assign host_wr = chipselect && write;
    assign host_rd = chipselect && read;

    // Control writes are dropped while a flit is pending
    assign send_start = host_wr && (address == 4'h0) && writedata[0] &&
                        (send_state == SEND_IDLE);

    assign output_read = host_rd && (address >= 4'h6) && (address <= 4'h9);

    assign flit_valid   = (send_state == SEND_WAIT);
    assign result_ready = 1'b1;

    // Control register and send FSM
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            control_reg <= '0;
            send_state  <= SEND_IDLE;
            flit_q      <= '0;
        end else begin
            case (send_state)
                SEND_IDLE: begin
                    if (host_wr && (address == 4'h0)) begin
                        control_reg <= writedata;
                    end
                    if (send_start) begin
                        send_state  <= SEND_WAIT;
                        flit_q.kind <= kind_t'(writedata[6:5]);
                        flit_q.dest <= dest_t'(writedata[4:1]);
                        // Instruction word goes out zero-extended
                        if (kind_t'(writedata[6:5]) == KIND_INSTR) begin
                            flit_q.data <= data_t'(instr_reg);
                        end else begin
                            flit_q.data <= input_reg;
                        end
                    end
                end
                SEND_WAIT: begin
                    if (flit_ready) begin
                        control_reg[0] <= 1'b0;
                        send_state     <= SEND_IDLE;
                    end
                end
                default: send_state <= SEND_IDLE;
            endcase
        end
    end

    // Input and instruction registers
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            input_reg <= '0;
            instr_reg <= '0;
        end else if (host_wr) begin
            case (address)
                4'h1: input_reg[31:0]   <= writedata;
                4'h2: input_reg[63:32]  <= writedata;
                4'h3: input_reg[95:64]  <= writedata;
                4'h4: input_reg[127:96] <= writedata;
                4'h5: instr_reg         <= writedata;
                default: ;
            endcase
        end
    end

    // Result capture, a new result wins over a clearing read
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            output_reg <= '0;
            result_rdy <= 1'b0;
        end else if (result_valid && result_ready) begin
            output_reg <= result;
            result_rdy <= 1'b1;
        end else if (output_read) begin
            result_rdy <= 1'b0;
        end
    end

    always_comb begin
        case (address)
            4'h0:    read_word = control_reg;
            4'h1:    read_word = input_reg[31:0];
            4'h2:    read_word = input_reg[63:32];
            4'h3:    read_word = input_reg[95:64];
            4'h4:    read_word = input_reg[127:96];
            4'h5:    read_word = instr_reg;
            4'h6:    read_word = output_reg.lane[0];
            4'h7:    read_word = output_reg.lane[1];
            4'h8:    read_word = output_reg.lane[2];
            4'h9:    read_word = output_reg.lane[3];
            4'hA:    read_word = {30'b0, flit_valid, result_rdy};
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            readdata <= '0;
        end else if (host_rd) begin
            readdata <= read_word;
        end
    end

    assign led_out = output_reg.lane[0][9:0];

    mvm_core i_mvm_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .flit_valid   (flit_valid),
        .flit_ready   (flit_ready),
        .flit         (flit_q),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: mlp_pkg.sv
`default_nettype none

package mlp_pkg;

    // Lane count, which is also the matrix size
    localparam int N_LANES = 4;

    // Host register word
    typedef logic [31:0] word_t;

    // Flit payload of four 32-bit lanes
    typedef logic [127:0] data_t;

    // Vector element or weight, in the low half of a lane
    typedef logic signed [15:0] elem_t;

    // Lane result
    typedef logic signed [31:0] acc_t;

    typedef logic [1:0] kind_t;
    typedef logic [3:0] dest_t;

    // Flit kinds, code 3 is dropped by the core
    localparam kind_t KIND_INSTR  = 2'd0;
    localparam kind_t KIND_WEIGHT = 2'd1;
    localparam kind_t KIND_INPUT  = 2'd2;

    typedef struct packed {
        kind_t kind;
        dest_t dest;
        data_t data;
    } stream_flit_t;

    // Lane 0 sits in the lowest 32 bits
    typedef struct packed {
        acc_t [N_LANES-1:0] lane;
    } result_t;

    // Taken from bits 4:0 of an instruction flit, relu in bit 4
    typedef struct packed {
        logic       relu;
        logic [3:0] shift;
    } mode_t;

    typedef enum logic {
        SEND_IDLE,
        SEND_WAIT
    } send_state_e;

endpackage

`default_nettype wire

// File: mlp_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_properties import mlp_pkg::*; (
    input logic         clk,
    input logic         reset_n,
    input logic         flit_valid,
    input logic         flit_ready,
    input stream_flit_t flit,
    input logic         result_valid,
    input logic         result_ready
);

    int unsigned failures = 0;
    logic        input_accept;

    assign input_accept = flit_valid && flit_ready && (flit.kind == KIND_INPUT);

    // Offered flit holds until the core takes it
    flit_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (flit_valid && !flit_ready) |=> (flit_valid && $stable(flit)))
        else begin
            failures++;
            $error("flit or flit_valid changed while flit_ready was low");
        end

    // Three stages between an accepted input and its result
    result_latency: assert property (@(posedge clk) disable iff (!reset_n)
        (input_accept && result_ready) |-> ##3 result_valid)
        else begin
            failures++;
            $error("result_valid did not follow an input flit after three cycles");
        end

    reset_quiet: assert property (@(posedge clk)
        !reset_n |=> (!flit_valid && !result_valid))
        else begin
            failures++;
            $error("a valid was high during reset");
        end

endmodule

bind mvm_core mlp_properties i_mlp_properties (
    .clk          (clk),
    .reset_n      (reset_n),
    .flit_valid   (flit_valid),
    .flit_ready   (flit_ready),
    .flit         (flit),
    .result_valid (result_valid),
    .result_ready (result_ready)
);

`default_nettype wire

// File: mvm_core.sv
`timescale 1ns/1ps
`default_nettype none

module mvm_core import mlp_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         flit_valid,
    output logic         flit_ready,
    input  stream_flit_t flit,
    output logic         result_valid,
    input  logic         result_ready,
    output result_t      result
);

    mode_t mode_q;
    logic  handshake;
    logic  pipe_in_valid;
    logic  pipe_in_ready;
    logic  row_write;
    elem_t [N_LANES-1:0][N_LANES-1:0] matrix;

    // Only input flits can be held back by the pipeline
    assign flit_ready = (flit.kind == KIND_INPUT) ? pipe_in_ready : 1'b1;
    assign handshake  = flit_valid && flit_ready;

    assign row_write     = handshake && (flit.kind == KIND_WEIGHT);
    assign pipe_in_valid = flit_valid && (flit.kind == KIND_INPUT);

    // Instruction flits set relu and shift
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mode_q <= '0;
        end else if (handshake && (flit.kind == KIND_INSTR)) begin
            mode_q <= mode_t'(flit.data[4:0]);
        end
    end

    mvm_weight_bank i_mvm_weight_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .row_write (row_write),
        .row_index (flit.dest[1:0]),
        .row_data  (flit.data),
        .matrix    (matrix)
    );

    mvm_dot_pipeline i_mvm_dot_pipeline (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (pipe_in_valid),
        .in_ready   (pipe_in_ready),
        .vector     (flit.data),
        .matrix     (matrix),
        .mode       (mode_q),
        .out_valid  (result_valid),
        .out_ready  (result_ready),
        .out_result (result)
    );

endmodule

`default_nettype wire

// File: mvm_dot_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mvm_dot_pipeline import mlp_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    in_valid,
    output logic    in_ready,
    input  data_t   vector,
    input  elem_t [N_LANES-1:0][N_LANES-1:0] matrix,
    input  mode_t   mode,
    output logic    out_valid,
    input  logic    out_ready,
    output result_t out_result
);

    logic  stall;

    // Stage 1 products
    logic  s1_valid;
    acc_t  [N_LANES-1:0][N_LANES-1:0] s1_prod;
    mode_t s1_mode;

    // Stage 2 lane sums
    logic  s2_valid;
    acc_t  [N_LANES-1:0] s2_sum;
    mode_t s2_mode;
    acc_t  [N_LANES-1:0] lane_sum;

    // Stage 3 result
    logic    s3_valid;
    result_t s3_result;
    result_t post;

    // Everything holds while the last stage waits
    assign stall    = s3_valid && !out_ready;
    assign in_ready = !stall;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            lane_sum[i] = '0;
            for (int j = 0; j < N_LANES; j++) begin
                lane_sum[i] = lane_sum[i] + s1_prod[i][j];
            end
        end
    end

    // Arithmetic shift, then clamp at zero under relu
    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            post.lane[i] = $signed(s2_sum[i]) >>> s2_mode.shift;
            if (s2_mode.relu && post.lane[i][31]) begin
                post.lane[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int i = 0; i < N_LANES; i++) begin
                for (int j = 0; j < N_LANES; j++) begin
                    s1_prod[i][j] <= $signed(matrix[i][j]) *
                                     $signed(vector[32*j +: 16]);
                end
            end
            s1_mode   <= mode;
            s2_sum    <= lane_sum;
            s2_mode   <= s1_mode;
            s3_result <= post;
        end
    end

    assign out_valid  = s3_valid;
    assign out_result = s3_result;

endmodule

`default_nettype wire

// File: mvm_weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mvm_weight_bank import mlp_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       row_write,
    input  logic [1:0] row_index,
    input  data_t      row_data,
    output elem_t [N_LANES-1:0][N_LANES-1:0] matrix
);

    // weights[i][j] is row i, column j
    elem_t [N_LANES-1:0][N_LANES-1:0] weights;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            weights <= '0;
        end else if (row_write) begin
            // Weight j sits in the low half of lane j
            for (int j = 0; j < N_LANES; j++) begin
                weights[row_index][j] <= elem_t'(row_data[32*j +: 16]);
            end
        end
    end

    assign matrix = weights;

endmodule

`default_nettype wire

// File: tb_mlp_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mlp_controller import mlp_pkg::*; ();

    localparam int POLL_LIMIT = 100;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       chipselect;
    logic       read;
    logic       write;
    logic [3:0] address;
    word_t      writedata;
    word_t      readdata;
    logic [9:0] led_out;

    integer  seed;
    // Host copy of the weights and the mode
    elem_t [N_LANES-1:0][N_LANES-1:0] weights;
    mode_t   host_mode;
    data_t   vector;
    word_t   rd_word;
    word_t   wr_words [1:5];
    result_t expected;

    always #20 clk = ~clk;

    mlp_controller i_mlp_controller (
        .clk        (clk),
        .reset_n    (reset_n),
        .chipselect (chipselect),
        .read       (read),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .readdata   (readdata),
        .led_out    (led_out)
    );

    // Lane i is the wrapped dot product of row i, shifted, then clamped under relu
    function automatic result_t mvm_expect(input elem_t [N_LANES-1:0][N_LANES-1:0] w,
                                           input data_t vec, input mode_t m);
        result_t r;
        acc_t    sum;
        acc_t    a;
        acc_t    b;
        for (int i = 0; i < N_LANES; i++) begin
            sum = '0;
            for (int j = 0; j < N_LANES; j++) begin
                a = $signed(w[i][j]);
                b = $signed(vec[32*j +: 16]);
                sum = sum + a * b;
            end
            sum = sum >>> m.shift;
            if (m.relu && sum < 0) begin
                sum = '0;
            end
            r.lane[i] = sum;
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_led(input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: led_out got 0x%03h expected 0x%03h", got, exp));
        end
    endtask

    task automatic bus_write(input logic [3:0] addr, input word_t data);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
    endtask

    // readdata is registered, so sample it half a cycle after the read edge
    task automatic bus_read(input logic [3:0] addr, output word_t data);
        @(posedge clk);
        chipselect <= 1'b1;
        read       <= 1'b1;
        address    <= addr;
        @(posedge clk);
        chipselect <= 1'b0;
        read       <= 1'b0;
        @(negedge clk);
        data = readdata;
    endtask

    // Status is read in the cycle the new flit is offered
    task automatic write_control_read_status(input word_t ctrl, output word_t status);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= 4'h0;
        writedata  <= ctrl;
        @(posedge clk);
        write      <= 1'b0;
        read       <= 1'b1;
        address    <= 4'hA;
        @(posedge clk);
        chipselect <= 1'b0;
        read       <= 1'b0;
        @(negedge clk);
        status = readdata;
    endtask

    task automatic wait_status(input int idx, input logic value, input string what);
        word_t status;
        int    polls = 0;
        bus_read(4'hA, status);
        while (status[idx] !== value) begin
            if (polls >= POLL_LIMIT) begin
                abort_run($sformatf("Timed out waiting for %s", what));
            end
            polls++;
            bus_read(4'hA, status);
        end
    endtask

    task automatic send_flit(input kind_t kind, input dest_t dest);
        bus_write(4'h0, {25'b0, kind, dest, 1'b1});
        wait_status(1, 1'b0, "the send to finish");
    endtask

    task automatic load_input(input data_t data);
        for (int j = 0; j < N_LANES; j++) begin
            bus_write(4'h1 + 4'(j), data[32*j +: 32]);
        end
    endtask

    task automatic set_mode(input logic relu, input logic [3:0] shift);
        host_mode.relu  = relu;
        host_mode.shift = shift;
        bus_write(4'h5, {27'b0, relu, shift});
        send_flit(KIND_INSTR, 4'h0);
    endtask

    // Upper lane halves and upper dest bits get random filler
    task automatic load_weights();
        data_t row;
        dest_t dest;
        for (int i = 0; i < N_LANES; i++) begin
            for (int j = 0; j < N_LANES; j++) begin
                row[32*j +: 32] = {16'($random(seed)), weights[i][j]};
            end
            load_input(row);
            dest = 4'($random(seed));
            dest[1:0] = 2'(i);
            send_flit(KIND_WEIGHT, dest);
        end
    endtask

    task automatic random_vector(output data_t v);
        for (int j = 0; j < N_LANES; j++) begin
            v[32*j +: 32] = $random(seed);
        end
    endtask

    task automatic compare_result(input result_t exp);
        word_t got;
        for (int i = 0; i < N_LANES; i++) begin
            bus_read(4'h6 + 4'(i), got);
            check_word($sformatf("output word %0d", i), got, exp.lane[i]);
        end
        check_led(led_out, exp.lane[0][9:0]);
        bus_read(4'hA, got);
        check_word("status", got, '0);
    endtask

    task automatic run_vector(input data_t v);
        result_t exp;
        exp = mvm_expect(weights, v, host_mode);
        load_input(v);
        send_flit(KIND_INPUT, 4'h0);
        wait_status(0, 1'b1, "a result");
        compare_result(exp);
    endtask

    initial begin
        reset_n    = 1'b0;
        chipselect = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        seed       = 32'h56ad_c5d7;
        host_mode  = '0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        for (int a = 0; a <= 10; a++) begin
            bus_read(4'(a), rd_word);
            check_word($sformatf("readdata at 0x%h", a), rd_word, '0);
        end
        check_led(led_out, '0);

        for (int a = 1; a <= 5; a++) begin
            wr_words[a] = $random(seed);
            bus_write(4'(a), wr_words[a]);
        end
        for (int a = 1; a <= 5; a++) begin
            bus_read(4'(a), rd_word);
            check_word($sformatf("readdata at 0x%h", a), rd_word, wr_words[a]);
        end
        // Kind 3, dest 5, send
        write_control_read_status(32'h0000_006b, rd_word);
        check_word("status", rd_word, 32'h0000_0002);
        wait_status(1, 1'b0, "the send to finish");
        bus_read(4'h0, rd_word);
        check_word("control", rd_word, 32'h0000_006a);

        for (int i = 0; i < N_LANES; i++) begin
            for (int j = 0; j < N_LANES; j++) begin
                weights[i][j] = 16'($random(seed));
            end
        end
        load_weights();
        set_mode(1'b0, 4'd0);
        random_vector(vector);
        run_vector(vector);

        repeat (20) begin
            set_mode(1'b1, 4'($random(seed)));
            random_vector(vector);
            run_vector(vector);
        end

        // Input in flight keeps its mode while a new instruction follows it
        set_mode(1'b0, 4'd3);
        random_vector(vector);
        expected = mvm_expect(weights, vector, host_mode);
        load_input(vector);
        bus_write(4'h5, 32'h0000_0012);
        bus_write(4'h0, {25'b0, KIND_INPUT, 4'h0, 1'b1});
        send_flit(KIND_INSTR, 4'h0);
        wait_status(0, 1'b1, "a result");
        compare_result(expected);
        host_mode = mode_t'(5'h12);
        random_vector(vector);
        run_vector(vector);

        // Kind 3 must leave weights and mode alone
        random_vector(vector);
        load_input(vector);
        bus_write(4'h5, $random(seed));
        send_flit(2'd3, 4'h1);
        random_vector(vector);
        run_vector(vector);

        if (i_mlp_controller.i_mvm_core.i_mlp_properties.failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("Assertion failures seen in the core");
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
mlp_pkg.sv
mvm_weight_bank.sv
mvm_dot_pipeline.sv
mvm_core.sv
mlp_controller.sv
mlp_properties.sv
tb_mlp_controller.sv
